// ==== project.f ====
rtl/bch_pkg.sv
rtl/lfsr_counter.sv
rtl/bch_encode.sv
rtl/msg_serializer.sv
rtl/codeword_collector.sv
rtl/bch_encoder_top.sv
verif/bch_encoder_asserts.sv
verif/tb_bch_encoder.sv

// ==== rtl/bch_encode.sv ====
module bch_encode (
	input logic clk,
	input logic reset,
	input logic din,
	output logic vdin,
	output logic dout
);

	import bch_pkg::*;

	localparam int p_w = bch_n - bch_k;

	// Counter states at the last data cycle and the last parity cycle.
	localparam logic [bch_m-1:0] count_last_data = bch_m'(lfsr_count(bch_m, bch_k - 1));
	localparam logic [bch_m-1:0] count_last_frame = bch_m'(lfsr_count(bch_m, bch_n - 1));

	logic [bch_m-1:0] count;
	logic window;
	parity_t lfsr;
	logic feedback;

	lfsr_counter #(
		.m(bch_m)
	) u_counter (
		.clk(clk),
		.reset(reset),
		.count(count)
	);

	// ########################################
	// Frame window
	// ########################################

	assign vdin = window & ~reset;	// Window is closed while reset is held.

	always_ff @(posedge clk) begin
		if (reset || count == count_last_frame)
			window <= 1'b1;	// Open for the next K data bits.
		else if (count == count_last_data)
			window <= 1'b0;	// Parity phase follows.
	end

	// ########################################
	// Parity LFSR
	// ########################################

	assign feedback = vdin & (lfsr[p_w-1] ^ din);

	always_ff @(posedge clk) begin
		if (reset)
			lfsr <= '0;
		else
			lfsr <= {lfsr[p_w-2:0], 1'b0} ^ ({p_w{feedback}} & bch_gen_poly);
	end

	// Data passes through, then the remainder shifts out MSB first.
	always_ff @(posedge clk) begin
		dout <= vdin ? din : lfsr[p_w-1];
	end

endmodule

// ==== rtl/bch_encoder_top.sv ====
module bch_encoder_top (
	input logic clk,
	input logic reset,
	input bch_pkg::msg_t msg,
	output logic msg_take,
	output bch_pkg::codeword_t cw,
	output logic cw_valid
);

	logic din;	// Serial message into the encoder.
	logic vdin;	// Encoder data window.
	logic dout;	// Serial codeword.

	// ########################################
	// Serial path
	// ########################################

	msg_serializer u_serializer (
		.clk(clk),
		.reset(reset),
		.vdin(vdin),
		.msg(msg),
		.msg_take(msg_take),
		.din(din)
	);

	bch_encode u_encode (
		.clk(clk),
		.reset(reset),
		.din(din),
		.vdin(vdin),
		.dout(dout)
	);

	codeword_collector u_collector (
		.clk(clk),
		.reset(reset),
		.vdin(vdin),
		.dout(dout),
		.cw(cw),
		.cw_valid(cw_valid)
	);

endmodule

// ==== rtl/bch_pkg.sv ====
package bch_pkg;

	// ########################################
	// Code constants
	// ########################################

	localparam int bch_n = 15;	// Codeword length.
	localparam int bch_k = 5;	// Message length.
	localparam int bch_t = 3;	// Correctable errors.
	localparam int bch_max_m = 8;	// Largest field degree with a known primitive polynomial.

	typedef logic [bch_k-1:0] msg_t;
	typedef logic [bch_n-bch_k-1:0] parity_t;

	typedef struct packed {
		msg_t data;	// Sent first, MSB first.
		parity_t parity;	// Sent after the data.
	} codeword_t;

	// ########################################
	// Galois field helpers
	// ########################################

	// Field degree needed for a code of length n.
	function automatic int n2m(int n);
		int m;
		m = 0;
		while ((1 << m) - 1 < n)
			m = m + 1;
		return m;
	endfunction

	// Low coefficients of the primitive polynomial, leading term dropped.
	function automatic logic [bch_max_m-1:0] prim_poly(int m);
		case (m)
			2: return 8'h03;	// x^2+x+1.
			3: return 8'h03;	// x^3+x+1.
			4: return 8'h03;	// x^4+x+1.
			5: return 8'h05;	// x^5+x^2+1.
			6: return 8'h03;	// x^6+x+1.
			7: return 8'h03;	// x^7+x+1.
			default: return 8'h1d;	// x^8+x^4+x^3+x^2+1.
		endcase
	endfunction

	// Fibonacci taps are the primitive polynomial reversed within m bits.
	function automatic logic [bch_max_m-1:0] fib_taps(int m);
		logic [bch_max_m-1:0] p;
		logic [bch_max_m-1:0] taps;
		int i;
		p = prim_poly(m);
		taps = '0;
		for (i = 0; i < m; i = i + 1)
			taps[m-1-i] = p[i];
		return taps;
	endfunction

	function automatic int gf_mul(int m, int a, int b);
		int r;
		int p;
		int i;
		r = 0;
		p = (1 << m) | int'(prim_poly(m));
		for (i = m - 1; i >= 0; i = i - 1) begin
			r = r << 1;
			if (((r >> m) & 1) != 0)
				r = r ^ p;	// Reduce modulo the field polynomial.
			if (((b >> i) & 1) != 0)
				r = r ^ a;
		end
		return r;
	endfunction

	// State of lfsr_counter after a number of steps from reset.
	function automatic int lfsr_count(int m, int steps);
		int s;
		int taps;
		int i;
		s = 1;
		taps = int'(fib_taps(m));
		for (i = 0; i < steps; i = i + 1)
			s = ((s << 1) | (^(s & taps))) & ((1 << m) - 1);
		return s;
	endfunction

	// Product of (x + a^e) over the cyclotomic cosets of a^1 to a^2t.
	function automatic parity_t encoder_poly(int m, int t);
		int g [0:bch_n];
		logic [bch_n-1:0] root;
		parity_t ret;
		int n;
		int e;
		int i;
		int j;
		int a;
		int deg;
		n = (1 << m) - 1;
		root = '0;
		for (j = 1; j <= 2 * t; j = j + 1) begin
			e = j % n;
			for (i = 0; i < m; i = i + 1) begin
				root[e] = 1'b1;
				e = (2 * e) % n;
			end
		end
		for (i = 0; i <= bch_n; i = i + 1)
			g[i] = 0;
		g[0] = 1;
		deg = 0;
		for (e = 0; e < n; e = e + 1) begin
			if (root[e]) begin
				a = 1;
				for (j = 0; j < e; j = j + 1)
					a = gf_mul(m, a, 2);	// Power of the primitive element.
				for (i = deg + 1; i > 0; i = i - 1)
					g[i] = g[i-1] ^ gf_mul(m, g[i], a);
				g[0] = gf_mul(m, g[0], a);
				deg = deg + 1;
			end
		end
		for (i = 0; i < bch_n - bch_k; i = i + 1)
			ret[i] = (g[i] != 0);	// Coefficients end up in GF(2).
		return ret;
	endfunction

	localparam int bch_m = n2m(bch_n);
	localparam parity_t bch_gen_poly = encoder_poly(bch_m, bch_t);

endpackage

// ==== rtl/codeword_collector.sv ====
module codeword_collector (
	input logic clk,
	input logic reset,
	input logic vdin,
	input logic dout,
	output bch_pkg::codeword_t cw,
	output logic cw_valid
);

	import bch_pkg::*;

	localparam logic [3:0] last_bit = 4'(bch_n - 1);

	logic vdin_d;	// Window aligned with dout.
	logic vdin_dd;
	logic first;
	logic active;
	logic [3:0] bit_cnt;
	logic [bch_n-2:0] shift;	// The last bit is taken straight from dout.

	assign first = vdin_d & ~vdin_dd;	// First data bit of a frame on dout.
	assign active = first | (bit_cnt != 4'd0);

	always_ff @(posedge clk) begin
		if (reset) begin
			vdin_d <= 1'b0;
			vdin_dd <= 1'b0;
		end else begin
			vdin_d <= vdin;
			vdin_dd <= vdin_d;
		end
	end

	// ########################################
	// Bit counter and strobe
	// ########################################

	always_ff @(posedge clk) begin
		if (reset) begin
			bit_cnt <= 4'd0;
			cw_valid <= 1'b0;
		end else begin
			cw_valid <= 1'b0;
			if (active) begin
				if (bit_cnt == last_bit) begin
					bit_cnt <= 4'd0;
					cw_valid <= 1'b1;	// One cycle after the 15th bit.
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (active)
			shift <= {shift[bch_n-3:0], dout};
		if (active && bit_cnt == last_bit)
			cw <= codeword_t'({shift, dout});	// Serial order matches the struct.
	end

endmodule

// ==== rtl/lfsr_counter.sv ====
module lfsr_counter #(
	parameter int m = 4
) (
	input logic clk,
	input logic reset,
	output logic [m-1:0] count
);

	import bch_pkg::*;

	localparam logic [bch_max_m-1:0] taps = fib_taps(m);

	logic feedback;

	assign feedback = ^(count & taps[m-1:0]);	// Maximal length, 2^m-1 states.

	always_ff @(posedge clk) begin
		if (reset)
			count <= m'(1);	// All-zero state is never reached.
		else
			count <= {count[m-2:0], feedback};
	end

endmodule

// ==== rtl/msg_serializer.sv ====
module msg_serializer (
	input logic clk,
	input logic reset,
	input logic vdin,
	input bch_pkg::msg_t msg,
	output logic msg_take,
	output logic din
);

	import bch_pkg::*;

	logic vdin_prev;
	logic [bch_k-2:0] shift;

	// First cycle of each window, including the one right after reset.
	assign msg_take = vdin & ~vdin_prev;

	// The MSB goes straight out while the rest is loaded.
	assign din = msg_take ? msg[bch_k-1] : shift[bch_k-2];

	always_ff @(posedge clk) begin
		if (reset)
			vdin_prev <= 1'b0;
		else
			vdin_prev <= vdin;
	end

	always_ff @(posedge clk) begin
		if (msg_take)
			shift <= msg[bch_k-2:0];	// Remaining bits, MSB first.
		else if (vdin)
			shift <= {shift[bch_k-3:0], 1'b0};	// Empties to zero by the end of the window.
	end

endmodule

// ==== verif/bch_encoder_asserts.sv ====
module bch_encoder_asserts (
	input logic clk,
	input logic reset,
	input logic vdin,
	input logic msg_take,
	input logic cw_valid
);

	int fail_count = 0;	// Read back by the testbench.

	// ########################################
	// Frame timing
	// ########################################

	// Five data cycles, ten parity cycles, then the next window.
	frame_window: assert property (@(posedge clk) disable iff (reset)
		$rose(vdin) |-> vdin [*5] ##1 !vdin [*10] ##1 vdin)
	else begin
		$error("vdin window is not 5 cycles high then 10 low");
		fail_count = fail_count + 1;
	end

	// A take opens the window and its codeword follows 16 cycles later.
	take_on_window_start: assert property (@(posedge clk) disable iff (reset)
		msg_take |-> $rose(vdin) ##16 cw_valid)
	else begin
		$error("msg_take off the window start or cw_valid not 16 cycles later");
		fail_count = fail_count + 1;
	end

	valid_single_pulse: assert property (@(posedge clk) disable iff (reset)
		cw_valid |=> !cw_valid)
	else begin
		$error("cw_valid held longer than one cycle");
		fail_count = fail_count + 1;
	end

endmodule

bind bch_encoder_top bch_encoder_asserts u_asserts (
	.clk(clk),
	.reset(reset),
	.vdin(vdin),
	.msg_take(msg_take),
	.cw_valid(cw_valid)
);

// ==== verif/tb_bch_encoder.sv ====
module tb_bch_encoder;

	import bch_pkg::*;

	localparam int n_random = 40;
	localparam int n_first = n_random + 3;	// First word, random words, zero and all ones.
	localparam int n_after = 3;	// Codewords checked after the mid-frame reset.
	localparam int n_spare = n_after + 4;	// Takes around and after the mid-frame reset.
	localparam int timeout_cycles = (n_first + n_after + 4) * 15 + 40;
	localparam logic [14:0] gen_poly = 15'h537;	// x^10+x^8+x^5+x^4+x^2+x+1.

	logic clk;
	logic reset;
	msg_t msg;
	logic msg_take;
	codeword_t cw;
	logic cw_valid;

	msg_t stim_q[$];	// Messages still to be driven.
	msg_t exp_q[$];	// Messages taken, waiting for their codeword.
	int take_q[$];	// Cycle of each take.
	int cycle = 0;
	int cw_count = 0;
	int prev_valid = 0;
	logic have_prev = 1'b0;
	logic reset_d = 1'b0;

	bch_encoder_top i_dut (
		.clk(clk),
		.reset(reset),
		.msg(msg),
		.msg_take(msg_take),
		.cw(cw),
		.cw_valid(cw_valid)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ########################################
	// Reference model and checks
	// ########################################

	// Long division of m(x)*x^10 by the generator, remainder is the parity.
	function automatic codeword_t ref_encode(msg_t m);
		logic [14:0] rem;
		codeword_t c;
		int i;
		rem = {m, 10'b0};
		for (i = 14; i >= 10; i--) begin
			if (rem[i])
				rem = rem ^ (gen_poly << (i - 10));
		end
		c.data = m;
		c.parity = rem[9:0];
		return c;
	endfunction

	function automatic msg_t next_message();
		if (stim_q.size() > 0)
			return stim_q.pop_front();
		else
			return msg;	// Last message is encoded again once the list is used up.
	endfunction

	task automatic stop_with_failure();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_codeword(string name, codeword_t expected, codeword_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED: %s expected 0x%h actual 0x%h", name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_message(string name, msg_t expected, msg_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED: %s expected 0x%h actual 0x%h", name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_bit(string name, logic expected, logic actual);
		if (actual !== expected) begin
			$display("CHECK FAILED: %s expected 0x%h actual 0x%h", name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_strobe_gap(string name, int expected, int actual);
		if (actual !== expected) begin
			$display("CHECK FAILED: %s expected 0x%h actual 0x%h", name, expected, actual);
			stop_with_failure();
		end
	endtask

	// ########################################
	// Driver and compare
	// ########################################

	always @(posedge clk) begin
		if (reset) begin
			exp_q.delete();	// Frames in flight are lost.
			take_q.delete();
		end else if (msg_take) begin
			exp_q.push_back(msg);
			take_q.push_back(cycle);
			msg <= next_message();
		end
	end

	always @(posedge clk) begin
		msg_t m;
		int take_cycle;
		cycle <= cycle + 1;
		reset_d <= reset;
		if (cycle >= timeout_cycles) begin
			$display("Timeout: no codeword arrived in time, run stopped at cycle %0d", cycle);
			stop_with_failure();
		end else if (i_dut.u_asserts.fail_count != 0) begin
			$display("A frame timing assertion failed");
			stop_with_failure();
		end else if (reset) begin
			check_bit("msg_take", 1'b0, msg_take);
			if (reset_d)
				check_bit("cw_valid", 1'b0, cw_valid);	// Registered, clear from the second cycle.
			have_prev <= 1'b0;
		end else if (cw_valid) begin
			if (exp_q.size() == 0) begin
				$display("A codeword arrived with no message taken for it");
				stop_with_failure();
			end else begin
				m = exp_q.pop_front();
				take_cycle = take_q.pop_front();
				check_message("cw.data", m, cw.data);	// Systematic code.
				if (m == '0)
					check_codeword("cw", '0, cw);
				check_codeword("cw", ref_encode(m), cw);
				check_strobe_gap("msg_take to cw_valid", 16, cycle - take_cycle);
				if (have_prev)
					check_strobe_gap("cw_valid to cw_valid", 15, cycle - prev_valid);
				have_prev <= 1'b1;
				prev_valid <= cycle;
				cw_count <= cw_count + 1;
			end
		end
	end

	// ########################################
	// Test sequence
	// ########################################

	initial begin
		int i;
		int base;
		void'($urandom(32'ha439));
		reset = 1'b1;
		for (i = 0; i <= n_random; i++)
			stim_q.push_back(msg_t'($urandom()));
		stim_q.push_back(5'h00);
		stim_q.push_back(5'h1f);
		for (i = 0; i < n_spare; i++)
			stim_q.push_back(msg_t'($urandom()));
		msg = stim_q.pop_front();
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		wait (cw_count >= n_first);

		// Hit the parity phase of the next frame.
		do
			@(posedge clk);
		while (!msg_take);
		repeat (8) @(posedge clk);
		reset <= 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		base = cw_count;
		wait (cw_count >= base + n_after);
		repeat (2) @(posedge clk);

		if (i_dut.u_asserts.fail_count == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			$display("Frame timing assertions failed %0d times", i_dut.u_asserts.fail_count);
			stop_with_failure();
		end
	end

endmodule
